//--- common/lt_bus_pkg.sv
package lt_bus_pkg;

    typedef struct packed {
        logic        wr_en;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;    // one bit per byte lane
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;   // unmapped address
    } bus_rsp_t;

    // address map
    localparam logic [31:0] ram_base  = 32'h0000_0000;
    localparam int          ram_words = 1024;
    localparam logic [31:0] out_addr  = 32'h1000_0000;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        MISC_MEM = 7'b0001111,
        OP_IMM   = 7'b0010011,
        AUIPC    = 7'b0010111,
        STORE    = 7'b0100011,
        OP       = 7'b0110011,
        LUI      = 7'b0110111,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111,
        SYSTEM   = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // load and store widths
    localparam logic [2:0] LB   = 3'b000;
    localparam logic [2:0] LH   = 3'b001;
    localparam logic [2:0] LW   = 3'b010;
    localparam logic [2:0] LBU  = 3'b100;
    localparam logic [2:0] LHU  = 3'b101;
    localparam logic [2:0] SB   = 3'b000;
    localparam logic [2:0] SH   = 3'b001;
    localparam logic [2:0] SW   = 3'b010;

    // branch conditions
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    typedef struct packed {
        rv_opcode_e      opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic [xlen-1:0] imm;       // already sign extended
        alu_op_e         alu_op;
        logic            use_imm;   // alu b operand is imm, not rs2
        logic            rd_we;
    } rv_decoded_t;

endpackage

//--- core/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 bus_enable,
    output lt_bus_pkg::bus_req_t req,
    input  logic                 ready,
    input  lt_bus_pkg::bus_rsp_t rsp,
    output logic                 halted,
    output logic                 fault
);
    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_FETCH,
        EXECUTE,
        WAIT_LOAD,
        WAIT_STORE,
        RETIRE,
        HALT
    } state_e;

    state_e          state;
    logic [xlen-1:0] pc;            // address of the instruction in flight
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic [31:0]     instr_reg;
    logic [xlen-1:0] res;           // value written to rd at retire

    rv_decoded_t     dec;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            take_branch;
    logic [xlen-1:0] load_shifted;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] store_data;
    logic [3:0]      store_be;
    logic            is_ebreak;

    rv_decoder u_decoder (
        .instr (instr_reg),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd_we    (state == RETIRE && dec.rd_we),
        .rd       (dec.rd),
        .rd_data  (res),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .op          (dec.alu_op),
        .a           (alu_a),
        .b           (alu_b),
        .result      (alu_result),
        .funct3      (dec.funct3),
        .take_branch (take_branch)
    );

    assign pc_plus4  = pc + 32'd4;
    assign alu_b     = dec.use_imm ? dec.imm : rs2_data;
    assign is_ebreak = dec.funct3 == 3'b000 && dec.imm[11:0] == 12'h001;

    always_comb begin
        case (dec.opcode)
            AUIPC:   alu_a = pc;
            LUI:     alu_a = '0;    // imm passes straight through
            default: alu_a = rs1_data;
        endcase
    end

    // move the addressed byte or half down to bit 0
    assign load_shifted = rsp.rdata >> {req.addr[1:0], 3'b000};

    always_comb begin
        case (dec.funct3)
            LB:      load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
            LH:      load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
            LBU:     load_data = {24'b0, load_shifted[7:0]};
            LHU:     load_data = {16'b0, load_shifted[15:0]};
            LW:      load_data = load_shifted;
            default: load_data = '0;
        endcase
    end

    // replicate store data over the lanes, byte enable picks the lanes
    always_comb begin
        case (dec.funct3)
            SB: begin
                store_data = {4{rs2_data[7:0]}};
                store_be   = 4'b0001 << alu_result[1:0];
            end
            SH: begin
                store_data = {2{rs2_data[15:0]}};
                store_be   = alu_result[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                store_data = rs2_data;
                store_be   = 4'b1111;
            end
            default: begin
                store_data = rs2_data;
                store_be   = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH;
            pc         <= '0;
            bus_enable <= 1'b0;
            halted     <= 1'b0;
            fault      <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    req        <= '{wr_en: 1'b0, addr: pc, wdata: '0, be: 4'hf};
                    bus_enable <= 1'b1;
                    state      <= WAIT_FETCH;
                end
                WAIT_FETCH, WAIT_LOAD, WAIT_STORE: begin
                    if (ready) begin
                        bus_enable <= 1'b0;
                        if (rsp.err) begin
                            fault  <= 1'b1;
                            halted <= 1'b1;
                            state  <= HALT;
                        end else if (state == WAIT_FETCH) begin
                            instr_reg <= rsp.rdata;
                            state     <= EXECUTE;
                        end else begin
                            if (state == WAIT_LOAD) begin
                                res <= load_data;
                            end
                            state <= RETIRE;
                        end
                    end
                end
                EXECUTE: begin
                    next_pc <= pc_plus4;
                    res     <= alu_result;
                    state   <= RETIRE;
                    case (dec.opcode)
                        JAL: begin
                            next_pc <= pc + dec.imm;
                            res     <= pc_plus4;
                        end
                        JALR: begin
                            next_pc <= alu_result & ~32'd1;
                            res     <= pc_plus4;
                        end
                        BRANCH: begin
                            if (take_branch) begin
                                next_pc <= pc + dec.imm;
                            end
                        end
                        LOAD: begin
                            req        <= '{wr_en: 1'b0, addr: alu_result, wdata: '0, be: 4'hf};
                            bus_enable <= 1'b1;
                            state      <= WAIT_LOAD;
                        end
                        STORE: begin
                            req        <= '{wr_en: 1'b1, addr: alu_result,
                                            wdata: store_data, be: store_be};
                            bus_enable <= 1'b1;
                            state      <= WAIT_STORE;
                        end
                        SYSTEM: begin
                            if (is_ebreak) begin
                                halted <= 1'b1;
                                state  <= HALT;
                            end
                        end
                        default: ;  // ecall, csr and fence retire as no-ops
                    endcase
                end
                RETIRE: begin
                    pc    <= next_pc;
                    state <= FETCH;
                end
                HALT: state <= HALT;   // left only through reset
                default: state <= HALT;
            endcase
        end
    end

endmodule

//--- rtl/lt_bus.sv
`timescale 1ns/10ps

module lt_bus (
    input  logic                 clk,
    input  logic                 enable,
    input  lt_bus_pkg::bus_req_t req,
    output logic                 ready,
    output lt_bus_pkg::bus_rsp_t rsp,
    input  logic                 prog_we,
    input  logic [9:0]           prog_addr,
    input  logic [31:0]          prog_data,
    output logic [31:0]          out_data,
    output logic                 out_strobe
);
    import lt_bus_pkg::*;

    localparam int aw = $clog2(ram_words);

    logic [31:0]   mem [ram_words];
    logic [31:0]   ram_off;
    logic [aw-1:0] word_idx;
    logic          hit_ram;
    logic          hit_out;
    logic          start;       // first cycle the request is seen
    logic          out_write;

    assign ram_off   = req.addr - ram_base;
    assign word_idx  = ram_off[aw+1:2];
    assign hit_ram   = ram_off < 32'(ram_words * 4);
    assign hit_out   = req.addr == out_addr && req.be == 4'hf;   // full word only
    assign start     = enable && !ready;
    assign out_write = start && req.wr_en && hit_out;

    // ready follows one cycle after enable and lasts a single cycle
    always_ff @(posedge clk) begin
        ready <= start;
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;    // loader, used only under reset
        end else if (start && hit_ram && req.wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // synchronous read, answer lands in the ready cycle
    always_ff @(posedge clk) begin
        if (start) begin
            rsp.err   <= !(hit_ram || hit_out);
            rsp.rdata <= hit_ram ? mem[word_idx] : (hit_out ? out_data : 32'd0);
        end
    end

    always_ff @(posedge clk) begin
        out_strobe <= out_write;
        if (out_write) begin
            out_data <= req.wdata;
        end
    end

endmodule

//--- rtl/lt_top.sv
`timescale 1ns/10ps

module lt_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        prog_we,
    input  logic [9:0]  prog_addr,
    input  logic [31:0] prog_data,
    output logic [31:0] out_data,
    output logic        out_strobe,
    output logic        halted,
    output logic        fault
);
    import lt_bus_pkg::*;

    logic     bus_enable;
    logic     bus_ready;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    rv_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_enable (bus_enable),
        .req        (bus_req),
        .ready      (bus_ready),
        .rsp        (bus_rsp),
        .halted     (halted),
        .fault      (fault)
    );

    lt_bus u_bus (
        .clk        (clk),
        .enable     (bus_enable),
        .req        (bus_req),
        .ready      (bus_ready),
        .rsp        (bus_rsp),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .out_data   (out_data),
        .out_strobe (out_strobe)
    );

endmodule

//--- rtl/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_isa_pkg::alu_op_e op,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    output logic [31:0]         result,
    input  logic [2:0]          funct3,
    output logic                take_branch
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, lt_signed};
            SLTU:    result = {31'b0, lt_unsigned};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // branch condition on the same operands
    always_comb begin
        case (funct3)
            BEQ:     take_branch = a == b;
            BNE:     take_branch = a != b;
            BLT:     take_branch = lt_signed;
            BGE:     take_branch = !lt_signed;
            BLTU:    take_branch = lt_unsigned;
            BGEU:    take_branch = !lt_unsigned;
            default: take_branch = 1'b0;    // reserved encodings never branch
        endcase
    end

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
    input  logic [31:0]             instr,
    output rv_isa_pkg::rv_decoded_t dec
);
    import rv_isa_pkg::*;

    rv_opcode_e  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = rv_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediates, bits scattered over the word per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    always_comb begin
        dec         = '0;
        dec.opcode  = opcode;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.funct3  = funct3;
        dec.imm     = imm_i;
        dec.alu_op  = ADD;      // address and link arithmetic
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b0;
        case (opcode)
            LOAD:     dec.rd_we = 1'b1;
            STORE:    dec.imm = imm_s;
            OP_IMM: begin
                dec.rd_we  = 1'b1;
                dec.alu_op = alu_from_funct3(funct3, funct7[5] && funct3 == 3'b101);
            end
            OP: begin
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b0;
                dec.alu_op  = alu_from_funct3(funct3, funct7[5]);
            end
            LUI, AUIPC: begin
                dec.rd_we = 1'b1;
                dec.imm   = imm_u;
            end
            BRANCH: begin
                dec.imm     = imm_b;
                dec.use_imm = 1'b0;     // comparator needs rs2
                dec.alu_op  = SUB;
            end
            JAL: begin
                dec.rd_we = 1'b1;
                dec.imm   = imm_j;
            end
            JALR:     dec.rd_we = 1'b1;
            MISC_MEM: dec.rd_we = 1'b0; // fence does nothing here
            default:  dec.rd_we = 1'b0; // system and unknown opcodes
        endcase
    end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        rd_we,
    input  logic [4:0]  rd,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rd_we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is never written, so it is masked on read
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

//--- tb/lt_core_chk.sv
`timescale 1ns/10ps

module lt_core_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 bus_enable,
    input lt_bus_pkg::bus_req_t req,
    input logic                 ready,
    input logic                 halted,
    input logic                 fault
);

    logic seen_failure = 1'b0;  // read by the testbench top

    // core leaves reset idle
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !bus_enable && !halted && !fault)
        else begin
            $error("bus_enable, halted or fault high in the first cycle after reset");
            seen_failure = 1'b1;
        end

    // request held steady until the bus answers
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_enable && !ready |=> $stable(req))
        else begin
            $error("request changed while waiting for ready");
            seen_failure = 1'b1;
        end

    enable_drop: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> !bus_enable)
        else begin
            $error("bus_enable still high in the cycle after ready");
            seen_failure = 1'b1;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            seen_failure = 1'b1;
        end

    // no bus traffic once halted, so no output write either
    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !bus_enable)
        else begin
            $error("bus request issued while halted");
            seen_failure = 1'b1;
        end

endmodule

//--- tb/tb_lt_top.sv
`timescale 1ns/10ps

module tb_lt_top;
    import rv_isa_pkg::*;

    localparam int          reset_cycles = 16;
    localparam int          max_words    = 64;  // longest test program
    localparam int          num_tests    = 6;
    localparam int          settle       = 20;  // cycles watched after halt
    localparam logic [31:0] ebreak_word  = 32'h0010_0073;

    logic        clk;
    logic        rst_n;
    logic        prog_we;
    logic [9:0]  prog_addr;
    logic [31:0] prog_data;
    logic [31:0] out_data;
    logic        out_strobe;
    logic        halted;
    logic        fault;

    logic [31:0] prog[$];       // program image from address 0
    logic [31:0] expect_q[$];   // expected out_data values in program order
    logic [31:0] rng_state;
    int          strobes;

    lt_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .out_data   (out_data),
        .out_strobe (out_strobe),
        .halted     (halted),
        .fault      (fault)
    );

    bind rv_core lt_core_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_enable (bus_enable),
        .req        (req),
        .ready      (ready),
        .halted     (halted),
        .fault      (fault)
    );

    always #5 clk = ~clk;

    task automatic stop_failed();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // sw rs to the output register whose address x31 holds
    task automatic store_out(input logic [4:0] rs, input logic [31:0] exp);
        emit(s_type(12'h000, rs, 5'd31, SW));
        expect_q.push_back(exp);
    endtask

    task automatic begin_program();
        prog.delete();
        expect_q.delete();
        emit(u_type(20'h10000, 5'd31, LUI));   // x31 = 0x1000_0000
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;       // addi adds the low part sign extended
        emit(u_type(upper[19:0], rd, LUI));
        emit(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        store_out(5'd3, exp);
    endtask

    task automatic load_out(input logic [2:0] f3, input logic [11:0] off,
                            input logic [31:0] exp);
        emit(i_type(off, 5'd5, f3, 5'd3, LOAD));
        store_out(5'd3, exp);
    endtask

    task automatic build_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [19:0] u;
        logic [11:0] imm;
        a   = next_rand() | 32'h8000_0000;  // a negative and b positive so signed ops differ
        b   = next_rand() & 32'h7fff_ffff;
        u   = 20'(next_rand());
        imm = 12'(next_rand());
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(i_type(imm, 5'd1, 3'b000, 5'd3, OP_IMM));
        store_out(5'd3, a + {{20{imm[11]}}, imm});
        emit(i_type(imm, 5'd1, 3'b100, 5'd3, OP_IMM));     // xori
        store_out(5'd3, a ^ {{20{imm[11]}}, imm});
        emit(i_type({7'b0100000, 5'd7}, 5'd1, 3'b101, 5'd3, OP_IMM));
        store_out(5'd3, 32'($signed(a) >>> 7));
        reg_op(7'h00, 3'b000, a + b);
        reg_op(7'h20, 3'b000, a - b);
        reg_op(7'h00, 3'b001, a << b[4:0]);
        reg_op(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
        reg_op(7'h00, 3'b011, {31'b0, a < b});
        reg_op(7'h00, 3'b100, a ^ b);
        reg_op(7'h00, 3'b101, a >> b[4:0]);
        reg_op(7'h20, 3'b101, 32'($signed(a) >>> b[4:0]));
        reg_op(7'h00, 3'b110, a | b);
        reg_op(7'h00, 3'b111, a & b);
        emit(u_type(u, 5'd3, LUI));
        store_out(5'd3, {u, 12'h000});
        pc = 32'(prog.size() * 4);
        emit(u_type(u, 5'd3, AUIPC));
        store_out(5'd3, pc + {u, 12'h000});
        emit(i_type(12'h005, 5'd1, 3'b000, 5'd0, OP_IMM)); // x0 stays zero
        store_out(5'd0, 32'd0);
        emit(ebreak_word);
    endtask

    task automatic build_loads();
        logic [31:0] d;
        d = (next_rand() | 32'h8000_8080) & 32'hff7f_ffff; // sign bits set in bytes 0, 1 and 3
        begin_program();
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd5, OP_IMM));
        load_const(5'd1, d);
        emit(s_type(12'h000, 5'd1, 5'd5, SW));
        load_out(LB, 12'd0, {{24{d[7]}}, d[7:0]});
        load_out(LB, 12'd1, {{24{d[15]}}, d[15:8]});
        load_out(LH, 12'd0, {{16{d[15]}}, d[15:0]});
        load_out(LH, 12'd2, {{16{d[31]}}, d[31:16]});
        load_out(LBU, 12'd3, {24'b0, d[31:24]});
        load_out(LHU, 12'd0, {16'b0, d[15:0]});
        load_out(LW, 12'd0, d);
        emit(ebreak_word);
    endtask

    task automatic build_partial();
        logic [31:0] w;
        logic [31:0] v;
        w = next_rand();
        v = next_rand();
        begin_program();
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd5, OP_IMM));
        load_const(5'd1, w);
        load_const(5'd2, v);
        emit(s_type(12'd0, 5'd1, 5'd5, SW));
        emit(s_type(12'd1, 5'd2, 5'd5, SB));
        emit(s_type(12'd2, 5'd2, 5'd5, SH));
        load_out(LW, 12'd0, {v[15:0], v[7:0], w[7:0]});
        emit(s_type(12'd4, 5'd1, 5'd5, SW));
        emit(s_type(12'd7, 5'd2, 5'd5, SB));
        emit(s_type(12'd4, 5'd2, 5'd5, SH));
        load_out(LW, 12'd4, {v[7:0], w[23:16], v[15:0]});
        emit(ebreak_word);
    endtask

    task automatic build_control();
        int n;
        int loop1;
        int loop2;
        int jal_pc;
        n = int'(next_rand() % 8) + 3;
        begin_program();
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd11, OP_IMM));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(i_type(12'(n), 5'd0, 3'b000, 5'd4, OP_IMM));
        loop1 = prog.size();
        emit(r_type(7'h00, 5'd2, 5'd11, 3'b000, 5'd11));   // sum += i
        emit(i_type(12'd1, 5'd2, 3'b000, 5'd2, OP_IMM));
        emit(b_type((loop1 - prog.size()) * 4, 5'd4, 5'd2, BNE));
        store_out(5'd11, 32'(n * (n - 1) / 2));
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd7, OP_IMM));
        emit(i_type(12'd0, 5'd0, 3'b000, 5'd8, OP_IMM));
        loop2 = prog.size();
        emit(i_type(12'd3, 5'd7, 3'b000, 5'd7, OP_IMM));
        emit(i_type(12'd1, 5'd8, 3'b000, 5'd8, OP_IMM));
        emit(b_type((loop2 - prog.size()) * 4, 5'd4, 5'd8, BLT));
        store_out(5'd7, 32'(3 * n));
        emit(b_type(8, 5'd4, 5'd0, BLT));                  // always taken so the store is skipped
        emit(s_type(12'h000, 5'd4, 5'd31, SW));
        jal_pc = prog.size() * 4;
        emit(j_type(12, 5'd1));                            // callee sits past the ebreak
        expect_q.push_back(32'h123);                       // written inside the call
        store_out(5'd1, 32'(jal_pc + 4));
        emit(ebreak_word);
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd10, OP_IMM));
        emit(s_type(12'h000, 5'd10, 5'd31, SW));
        emit(i_type(12'h000, 5'd1, 3'b000, 5'd0, JALR));
    endtask

    task automatic build_ebreak();
        logic [31:0] v;
        v = next_rand();
        begin_program();
        load_const(5'd3, v);
        store_out(5'd3, v);
        emit(ebreak_word);
        emit(s_type(12'h000, 5'd3, 5'd31, SW));            // never reached
    endtask

    task automatic build_fault();
        logic [31:0] v;
        v = next_rand();
        begin_program();
        load_const(5'd3, v);
        store_out(5'd3, v);
        emit(u_type(20'h20000, 5'd6, LUI));                // unmapped address
        emit(i_type(12'h000, 5'd6, LW, 5'd3, LOAD));
        emit(s_type(12'h000, 5'd3, 5'd31, SW));
        emit(ebreak_word);
    endtask

    task automatic run_program(input logic expect_fault);
        @(negedge clk);
        rst_n   = 1'b0;
        strobes = 0;
        foreach (prog[i]) begin
            prog_we   = 1'b1;
            prog_addr = 10'(i);
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        if (prog.size() < reset_cycles) begin
            repeat (reset_cycles - prog.size()) @(negedge clk);
        end
        rst_n = 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        assert (strobes == expect_q.size()) else begin
            abort_run($sformatf("core halted after %0d of %0d expected output writes",
                                strobes, expect_q.size()));
        end
        repeat (settle) @(negedge clk);
        assert (halted === 1'b1 && fault === expect_fault) else begin
            abort_run($sformatf("halted is %b and fault is %b, expected halted 1 and fault %b",
                                halted, fault, expect_fault));
        end
    endtask

    // output register monitor
    always @(posedge clk) begin
        if (rst_n === 1'b1 && out_strobe === 1'b1) begin
            assert (halted !== 1'b1) else begin
                abort_run("output strobe while the core was halted");
            end
            assert (strobes < expect_q.size()) else begin
                abort_run("output write that the program should not produce");
            end
            assert (out_data === expect_q[strobes]) else begin
                $display("error at %0t: output write %0d expected %h, got %h",
                         $time, strobes, expect_q[strobes], out_data);
                stop_failed();
            end
            strobes++;
        end
    end

    always @(posedge clk) begin
        assert (!i_dut.u_core.u_chk.seen_failure) else begin
            abort_run("a bus protocol or halt check on the core failed");
        end
    end

    initial begin
        repeat (200 * max_words * num_tests) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        strobes   = 0;
        rng_state = 32'd48;
        build_arith();
        run_program(1'b0);
        build_loads();
        run_program(1'b0);
        build_partial();
        run_program(1'b0);
        build_control();
        run_program(1'b0);
        build_ebreak();
        run_program(1'b0);
        build_fault();
        run_program(1'b1);
        if (i_dut.u_core.u_chk.seen_failure) begin
            abort_run("a bus protocol or halt check on the core failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
common/rv_isa_pkg.sv
common/lt_bus_pkg.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
core/rv_core.sv
rtl/lt_bus.sv
rtl/lt_top.sv
tb/lt_core_chk.sv
tb/tb_lt_top.sv
